//--- tb.f
design/safety_periph_pkg.sv
design/cl_regbus_decoder.sv
design/bus_err_unit.sv
design/irq_ctrl.sv
design/safety_periph_top.sv
verification/tb_safety_periph.sv

//--- run.sh
#!/bin/sh
# Builds the testbench and design with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_safety_periph -f tb.f -o sim
./obj_dir/sim | tee sim.log
if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "Simulation did not report success, see sim.log"
exit 1

//--- verification/tb_safety_periph.sv
/* Testbench for the core-local peripherals. Drives the AXI4-Lite port, the three
   observed memory buses and the interrupt sources, and checks them against models */
`timescale 1ns/1ps
`default_nettype none

module tb_safety_periph;
  import safety_periph_pkg::*;

  localparam int unsigned NumExtIrqs      = 16;
  localparam int unsigned NumSrc          = NumExtIrqs + 32;
  localparam int unsigned IdW             = $clog2(NumSrc);
  localparam int unsigned NumStoredErrors = 8;
  localparam addr_t       Base            = 32'h0020_0000;
  localparam int unsigned MaxCycles       = 4000; // Several times the full sequence

  logic                  clk_i, rst_n_i;
  logic                  s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
  logic                  s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
  addr_t                 s_awaddr_i, s_araddr_i;
  data_t                 s_wdata_i, s_rdata_o;
  logic [3:0]            s_wstrb_i;
  axi_resp_t             s_bresp_o, s_rresp_o;
  logic                  instr_req_i, instr_gnt_i, instr_rvalid_i;
  logic                  data_req_i, data_gnt_i, data_rvalid_i;
  logic                  shadow_req_i, shadow_gnt_i, shadow_rvalid_i;
  addr_t                 instr_addr_i, data_addr_i, shadow_addr_i;
  logic [1:0]            instr_err_i, data_err_i, shadow_err_i;
  logic [1:0]            timer_irqs_i;
  logic [NumExtIrqs-1:0] ext_irqs_i;
  logic                  irq_valid_o, irq_ready_i;
  logic [IdW-1:0]        irq_id_o;
  irq_level_t            irq_level_o;

  logic [31:0] lfsr_q = 32'h18f6;
  logic        en_m [NumSrc];
  irq_level_t  lvl_m [NumSrc];
  logic [33:0] log_m [$]; // Address and code of the active bus
  logic        log_ovf_m;
  int          active_bus;
  int          data_errs, resp_errs, irq_errs;

  safety_periph_top #(
    .PeriphBaseAddr ( Base       ),
    .NumExtIrqs     ( NumExtIrqs )
  ) safety_periph_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the sequence did not complete", cycles);
    $display("Test failed");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic src_level(int id);
    if (id >= IrqExtBase && id < IrqExtBase + NumExtIrqs) return ext_irqs_i[id - IrqExtBase];
    if (id >= IrqTimerBase && id < IrqTimerBase + 2) return timer_irqs_i[id - IrqTimerBase];
    if (id == IrqBusErrBase + active_bus) return log_m.size() != 0;
    return 1'b0;
  endfunction

  // Highest level wins; scanning down from the top id settles ties
  function automatic logic exp_irq(output logic [IdW-1:0] id, output irq_level_t lvl);
    logic found;
    found = 1'b0;
    id    = '0;
    lvl   = '0;
    for (int i = int'(NumSrc) - 1; i >= 0; i--) begin
      if (src_level(i) && en_m[i] && lvl_m[i] > lvl) begin
        found = 1'b1;
        id    = IdW'(i);
        lvl   = lvl_m[i];
      end
    end
    return found;
  endfunction

  function automatic void log_push(addr_t a, logic [1:0] e);
    if (log_m.size() < NumStoredErrors) begin
      log_m.push_back({a, e});
    end else begin
      log_ovf_m = 1'b1; // Entry dropped
    end
  endfunction

  function automatic data_t status_word();
    return {log_ovf_m, 23'd0, 8'(log_m.size())};
  endfunction

  function automatic addr_t err_window(int b);
    return Base + InstrErrOffset + addr_t'(b) * PeriphWindowSize;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_irq(input logic [IdW-1:0] got_id, input logic [IdW-1:0] exp_id,
                           input irq_level_t got_lvl, input irq_level_t exp_lvl);
    if (got_id !== exp_id) begin
      $display("FAIL irq_id_o got %h expected %h", got_id, exp_id);
      irq_errs++;
    end
    if (got_lvl !== exp_lvl) begin
      $display("FAIL irq_level_o got %h expected %h", got_lvl, exp_lvl);
      irq_errs++;
    end
  endtask

  task automatic axi_write(input addr_t addr, input data_t wdata, output axi_resp_t resp);
    @(negedge clk_i);
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_awaddr_i  = addr;
    s_wdata_i   = wdata;
    s_wstrb_i   = 4'hF;
    do @(posedge clk_i); while (!s_awready_o);
    // Address and data are taken in the same cycle
    if (s_wready_o !== 1'b1) begin
      $display("FAIL s_wready_o got %h expected %h", s_wready_o, 1'b1);
      resp_errs++;
    end
    @(negedge clk_i);
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b1;
    do @(posedge clk_i); while (!s_bvalid_o);
    resp = s_bresp_o;
    @(negedge clk_i);
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, output data_t rdata, output axi_resp_t resp);
    @(negedge clk_i);
    s_arvalid_i = 1'b1;
    s_araddr_i  = addr;
    do @(posedge clk_i); while (!s_arready_o);
    @(negedge clk_i);
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b1;
    do @(posedge clk_i); while (!s_rvalid_o);
    rdata = s_rdata_o;
    resp  = s_rresp_o;
    @(negedge clk_i);
    s_rready_i = 1'b0;
  endtask

  task automatic write_ok(input addr_t addr, input data_t wdata);
    axi_resp_t resp;
    axi_write(addr, wdata, resp);
    check_resp($sformatf("s_bresp_o at %h", addr), resp, RespOkay);
  endtask

  task automatic read_check(input addr_t addr, input data_t exp);
    data_t     rdata;
    axi_resp_t resp;
    axi_read(addr, rdata, resp);
    check_resp($sformatf("s_rresp_o at %h", addr), resp, RespOkay);
    check_data($sformatf("s_rdata_o at %h", addr), rdata, exp);
  endtask

  task automatic write_src_cfg(input int id, input data_t wdata);
    write_ok(Base + IrqCtrlOffset + addr_t'(4 * id), wdata);
    en_m[id]  = wdata[0];
    lvl_m[id] = wdata[15:8];
  endtask

  task automatic drive_bus(input int b, input logic req, input logic rvalid,
                           input addr_t addr, input logic [1:0] err);
    case (b)
      0: begin
        {instr_req_i, instr_gnt_i, instr_rvalid_i} = {req, req, rvalid};
        {instr_addr_i, instr_err_i} = {addr, err};
      end
      1: begin
        {data_req_i, data_gnt_i, data_rvalid_i} = {req, req, rvalid};
        {data_addr_i, data_err_i} = {addr, err};
      end
      default: begin
        {shadow_req_i, shadow_gnt_i, shadow_rvalid_i} = {req, req, rvalid};
        {shadow_addr_i, shadow_err_i} = {addr, err};
      end
    endcase
  endtask

  // In-order responses, never more than two pending
  task automatic run_traffic(input int b, input int n, input logic force_err);
    addr_t      pend [$];
    addr_t      a;
    logic [1:0] e;
    logic       do_req, do_rsp;
    int         issued, done;
    issued = 0;
    done   = 0;
    while (done < n) begin
      @(negedge clk_i);
      do_req = (issued < n) && (pend.size() < 2) && (rand_bits(1) != 0);
      do_rsp = (pend.size() > 0) && (rand_bits(1) != 0);
      a      = rand_bits(30) << 2;
      e      = do_rsp ? 2'(rand_bits(2)) : 2'b00;
      if (force_err && do_rsp && e == 2'b00) e = 2'b11;
      drive_bus(b, do_req, do_rsp, a, e);
      if (do_rsp) begin
        if (e != 2'b00) log_push(pend[0], e);
        void'(pend.pop_front());
        done++;
      end
      if (do_req) begin
        pend.push_back(a);
        issued++;
      end
    end
    @(negedge clk_i);
    drive_bus(b, 1'b0, 1'b0, '0, 2'b00);
  endtask

  task automatic drain_log(input int b);
    addr_t win;
    win = err_window(b);
    read_check(win + addr_t'(ErrRegStatus), status_word());
    while (log_m.size() != 0) begin
      read_check(win + addr_t'(ErrRegAddr), log_m[0][33:2]);
      read_check(win + addr_t'(ErrRegCode), data_t'(log_m[0][1:0]));
      write_ok(win + addr_t'(ErrRegPop), '0);
      void'(log_m.pop_front());
    end
    read_check(win + addr_t'(ErrRegStatus), status_word());
  endtask

  // Ready is harmless while valid is low
  task automatic ack_irq(input logic [1:0] timers, input logic [NumExtIrqs-1:0] ext);
    @(negedge clk_i);
    irq_ready_i  = 1'b1;
    timer_irqs_i = timers;
    ext_irqs_i   = ext;
    @(negedge clk_i);
    irq_ready_i = 1'b0;
  endtask

  // Selection is registered two edges after the sources
  task automatic check_selection();
    logic [IdW-1:0] id;
    irq_level_t     lvl;
    logic           found;
    repeat (3) @(negedge clk_i);
    found = exp_irq(id, lvl);
    if (irq_valid_o !== found) begin
      $display("FAIL irq_valid_o got %h expected %h", irq_valid_o, found);
      irq_errs++;
    end else if (found) begin
      check_irq(irq_id_o, id, irq_level_o, lvl);
    end
  endtask

  initial begin
    axi_resp_t resp;
    data_t     rdata;
    {s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i, irq_ready_i} = '0;
    {s_awaddr_i, s_araddr_i, s_wdata_i, s_wstrb_i} = '0;
    for (int b = 0; b < 3; b++) drive_bus(b, 1'b0, 1'b0, '0, 2'b00);
    timer_irqs_i = '0;
    ext_irqs_i   = '0;
    log_ovf_m    = 1'b0;
    active_bus   = 0;
    for (int i = 0; i < NumSrc; i++) begin
      en_m[i]  = 1'b0;
      lvl_m[i] = '0;
    end
    rst_n_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Unmapped space and ids past the last source
    axi_write(Base + 32'h4000, 32'h1234_5678, resp);
    check_resp("s_bresp_o unmapped", resp, RespSlvErr);
    axi_read(32'h0010_0000, rdata, resp);
    check_resp("s_rresp_o unmapped", resp, RespSlvErr);
    check_data("s_rdata_o unmapped", rdata, DecodeErrVal);
    axi_read(Base + addr_t'(4 * NumSrc), rdata, resp);
    check_resp("s_rresp_o past last source", resp, RespSlvErr);
    axi_write(Base + addr_t'(4 * NumSrc), '1, resp);
    check_resp("s_bresp_o past last source", resp, RespSlvErr);

    for (int i = 0; i < NumSrc; i++) write_src_cfg(i, rand_bits(32));
    for (int i = 0; i < NumSrc; i++) begin
      read_check(Base + addr_t'(4 * i), {16'd0, lvl_m[i], 7'd0, en_m[i]});
    end

    for (int b = 0; b < 3; b++) begin
      active_bus = b;
      run_traffic(b, 8, 1'b0);
      drain_log(b);
    end

    // Data bus overflow, then clear the sticky bit
    active_bus = 1;
    run_traffic(1, 10, 1'b1);
    drain_log(1);
    write_ok(err_window(1) + addr_t'(ErrRegPop), 32'h8000_0000);
    log_ovf_m = 1'b0;
    read_check(err_window(1) + addr_t'(ErrRegStatus), status_word());

    for (int b = 0; b < 3; b++) write_src_cfg(IrqBusErrBase + b, '0);
    for (int i = IrqTimerBase; i < IrqTimerBase + 2; i++) write_src_cfg(i, rand_bits(16));
    for (int i = IrqExtBase; i < NumSrc; i++) write_src_cfg(i, rand_bits(16));
    for (int r = 0; r < 6; r++) begin
      ack_irq(2'(rand_bits(2)), NumExtIrqs'(rand_bits(NumExtIrqs)));
      check_selection();
      ack_irq(2'(rand_bits(2)), NumExtIrqs'(rand_bits(NumExtIrqs)));
      check_selection();
      ack_irq('0, '0);
      check_selection();
    end

    // A pending log raises its bus error source
    for (int b = 0; b < 3; b++) begin
      active_bus = b;
      write_src_cfg(IrqBusErrBase + b, 32'h0000_FF01);
      run_traffic(b, 1, 1'b1);
      check_selection();
      drain_log(b);
      check_selection();
    end

    $display("Errors: data %0d, response %0d, interrupt %0d", data_errs, resp_errs, irq_errs);
    if (data_errs + resp_errs + irq_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/safety_periph_top.sv
/* Core-local peripherals of the safety island: register bus decoder, three
   bus error units and the interrupt controller, wired together */
`timescale 1ns/1ps
`default_nettype none

module safety_periph_top #(
  parameter safety_periph_pkg::addr_t PeriphBaseAddr  = 32'h0020_0000,
  parameter int unsigned              NumExtIrqs      = 16,
  parameter int unsigned              NumBusErrBits   = 2,
  parameter int unsigned              NumOutstanding  = 2,
  parameter int unsigned              NumStoredErrors = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                s_awvalid_i,
  output logic                                s_awready_o,
  input  safety_periph_pkg::addr_t            s_awaddr_i,
  input  logic                                s_wvalid_i,
  output logic                                s_wready_o,
  input  safety_periph_pkg::data_t            s_wdata_i,
  input  logic [3:0]                          s_wstrb_i,
  output logic                                s_bvalid_o,
  input  logic                                s_bready_i,
  output safety_periph_pkg::axi_resp_t        s_bresp_o,
  input  logic                                s_arvalid_i,
  output logic                                s_arready_o,
  input  safety_periph_pkg::addr_t            s_araddr_i,
  output logic                                s_rvalid_o,
  input  logic                                s_rready_i,
  output safety_periph_pkg::data_t            s_rdata_o,
  output safety_periph_pkg::axi_resp_t        s_rresp_o,
  input  logic                                instr_req_i,
  input  logic                                instr_gnt_i,
  input  logic                                instr_rvalid_i,
  input  safety_periph_pkg::addr_t            instr_addr_i,
  input  logic [NumBusErrBits-1:0]            instr_err_i,
  input  logic                                data_req_i,
  input  logic                                data_gnt_i,
  input  logic                                data_rvalid_i,
  input  safety_periph_pkg::addr_t            data_addr_i,
  input  logic [NumBusErrBits-1:0]            data_err_i,
  input  logic                                shadow_req_i,
  input  logic                                shadow_gnt_i,
  input  logic                                shadow_rvalid_i,
  input  safety_periph_pkg::addr_t            shadow_addr_i,
  input  logic [NumBusErrBits-1:0]            shadow_err_i,
  input  logic [1:0]                          timer_irqs_i,
  input  logic [NumExtIrqs-1:0]               ext_irqs_i,
  output logic                                irq_valid_o,
  input  logic                                irq_ready_i,
  output logic [$clog2(NumExtIrqs+32)-1:0]    irq_id_o,
  output safety_periph_pkg::irq_level_t       irq_level_o
);
  import safety_periph_pkg::*;

  logic [3:0]  reg_req, reg_error, reg_wstrb;
  logic        reg_we;
  reg_off_t    reg_addr;
  data_t       reg_wdata;
  data_t [3:0] reg_rdata;

  // Bus order matches the peer and interrupt order
  logic  [2:0]                    bus_req, bus_gnt, bus_rvalid, bus_err_irq;
  addr_t [2:0]                    bus_addr;
  logic  [2:0][NumBusErrBits-1:0] bus_err;
  logic  [NumExtIrqs+31:0]        irq_src;

  assign bus_req    = {shadow_req_i, data_req_i, instr_req_i};
  assign bus_gnt    = {shadow_gnt_i, data_gnt_i, instr_gnt_i};
  assign bus_rvalid = {shadow_rvalid_i, data_rvalid_i, instr_rvalid_i};
  assign bus_addr   = {shadow_addr_i, data_addr_i, instr_addr_i};
  assign bus_err    = {shadow_err_i, data_err_i, instr_err_i};

  cl_regbus_decoder #(
    .PeriphBaseAddr ( PeriphBaseAddr )
  ) cl_regbus_decoder_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .s_awvalid_i ( s_awvalid_i ),
    .s_awready_o ( s_awready_o ),
    .s_awaddr_i  ( s_awaddr_i  ),
    .s_wvalid_i  ( s_wvalid_i  ),
    .s_wready_o  ( s_wready_o  ),
    .s_wdata_i   ( s_wdata_i   ),
    .s_wstrb_i   ( s_wstrb_i   ),
    .s_bvalid_o  ( s_bvalid_o  ),
    .s_bready_i  ( s_bready_i  ),
    .s_bresp_o   ( s_bresp_o   ),
    .s_arvalid_i ( s_arvalid_i ),
    .s_arready_o ( s_arready_o ),
    .s_araddr_i  ( s_araddr_i  ),
    .s_rvalid_o  ( s_rvalid_o  ),
    .s_rready_i  ( s_rready_i  ),
    .s_rdata_o   ( s_rdata_o   ),
    .s_rresp_o   ( s_rresp_o   ),
    .reg_req_o   ( reg_req     ),
    .reg_we_o    ( reg_we      ),
    .reg_addr_o  ( reg_addr    ),
    .reg_wdata_o ( reg_wdata   ),
    .reg_wstrb_o ( reg_wstrb   ),
    .reg_rdata_i ( reg_rdata   ),
    .reg_error_i ( reg_error   )
  );

  for (genvar b = 0; b < 3; b++) begin : gen_bus_err
    bus_err_unit #(
      .NumBusErrBits   ( NumBusErrBits   ),
      .NumOutstanding  ( NumOutstanding  ),
      .NumStoredErrors ( NumStoredErrors )
    ) bus_err_unit_i (
      .clk_i        ( clk_i                                ),
      .rst_n_i      ( rst_n_i                              ),
      .bus_req_i    ( bus_req[b]                           ),
      .bus_gnt_i    ( bus_gnt[b]                           ),
      .bus_rvalid_i ( bus_rvalid[b]                        ),
      .bus_addr_i   ( bus_addr[b]                          ),
      .bus_err_i    ( bus_err[b]                           ),
      .reg_req_i    ( reg_req[int'(PeriphInstrErr) + b]    ),
      .reg_we_i     ( reg_we                               ),
      .reg_addr_i   ( reg_addr                             ),
      .reg_wdata_i  ( reg_wdata                            ),
      .reg_rdata_o  ( reg_rdata[int'(PeriphInstrErr) + b]  ),
      .reg_error_o  ( reg_error[int'(PeriphInstrErr) + b]  ),
      .err_irq_o    ( bus_err_irq[b]                       )
    );
  end

  // Unused source ids stay low
  always_comb begin
    irq_src = '0;
    irq_src[IrqTimerBase +: 2]           = timer_irqs_i;
    irq_src[IrqBusErrBase +: 3]          = bus_err_irq;
    irq_src[IrqExtBase +: NumExtIrqs]    = ext_irqs_i;
  end

  irq_ctrl #(
    .NumExtIrqs ( NumExtIrqs )
  ) irq_ctrl_i (
    .clk_i       ( clk_i              ),
    .rst_n_i     ( rst_n_i            ),
    .src_i       ( irq_src            ),
    .reg_req_i   ( reg_req[PeriphIrq]   ),
    .reg_we_i    ( reg_we             ),
    .reg_addr_i  ( reg_addr           ),
    .reg_wdata_i ( reg_wdata          ),
    .reg_wstrb_i ( reg_wstrb          ),
    .reg_rdata_o ( reg_rdata[PeriphIrq] ),
    .reg_error_o ( reg_error[PeriphIrq] ),
    .irq_valid_o ( irq_valid_o        ),
    .irq_ready_i ( irq_ready_i        ),
    .irq_id_o    ( irq_id_o           ),
    .irq_level_o ( irq_level_o        )
  );

endmodule

`default_nettype wire

//--- design/irq_ctrl.sv
/* Level-based interrupt controller. Each source has an enable and a level
   register; the highest pending level is offered with a valid/ready handshake */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl #(
  parameter  int unsigned NumExtIrqs = 16,
  localparam int unsigned NumSrc     = NumExtIrqs + 32,
  localparam int unsigned IdW        = $clog2(NumSrc)
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [NumSrc-1:0]              src_i,
  input  logic                           reg_req_i,
  input  logic                           reg_we_i,
  input  safety_periph_pkg::reg_off_t    reg_addr_i,
  input  safety_periph_pkg::data_t       reg_wdata_i,
  input  logic [3:0]                     reg_wstrb_i,
  output safety_periph_pkg::data_t       reg_rdata_o,
  output logic                           reg_error_o,
  output logic                           irq_valid_o,
  input  logic                           irq_ready_i,
  output logic [IdW-1:0]                 irq_id_o,
  output safety_periph_pkg::irq_level_t  irq_level_o
);
  import safety_periph_pkg::*;

  logic [NumSrc-1:0] src_q, en_q;
  irq_level_t        lvl_q [NumSrc];
  logic [IdW-1:0]    reg_id, best_id, id_q;
  irq_level_t        best_lvl, lvl_sel_q;
  logic              reg_hit, best_found, valid_q, held_pending;

  // One word per source
  assign reg_hit = (reg_addr_i[11:2] < 10'(NumSrc));
  assign reg_id  = IdW'(reg_addr_i[11:2]);

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    if (reg_req_i) begin
      if (!reg_hit) begin
        reg_error_o = 1'b1;
      end else if (!reg_we_i) begin
        reg_rdata_o = {16'd0, lvl_q[reg_id], 7'd0, en_q[reg_id]};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q <= '0;
      for (int i = 0; i < NumSrc; i++) begin
        lvl_q[i] <= '0;
      end
    end else if (reg_req_i && reg_we_i && reg_hit) begin
      if (reg_wstrb_i[0]) en_q[reg_id] <= reg_wdata_i[0];
      if (reg_wstrb_i[1]) lvl_q[reg_id] <= reg_wdata_i[15:8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q <= '0;
    end else begin
      src_q <= src_i;
    end
  end

  // Highest level wins, ties go to the higher id
  always_comb begin
    best_found = 1'b0;
    best_id    = '0;
    best_lvl   = '0;
    for (int i = 0; i < NumSrc; i++) begin
      if (src_q[i] && en_q[i] && (lvl_q[i] != '0) && (lvl_q[i] >= best_lvl)) begin
        best_found = 1'b1;
        best_id    = IdW'(i);
        best_lvl   = lvl_q[i];
      end
    end
  end

  assign held_pending = src_q[id_q] && en_q[id_q];

  // Valid drops for one cycle after the handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      if (irq_ready_i || !held_pending) valid_q <= 1'b0;
    end else begin
      valid_q <= best_found;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!valid_q && best_found) begin
      id_q      <= best_id;
      lvl_sel_q <= best_lvl;
    end
  end

  assign irq_valid_o = valid_q;
  assign irq_id_o    = id_q;
  assign irq_level_o = lvl_sel_q;

endmodule

`default_nettype wire

//--- design/bus_err_unit.sv
/* Watches one OBI memory bus and logs address and code of every erroneous
   response. The log is read and popped through the register bus */
`timescale 1ns/1ps
`default_nettype none

module bus_err_unit #(
  parameter int unsigned NumBusErrBits   = 2,
  parameter int unsigned NumOutstanding  = 2,
  parameter int unsigned NumStoredErrors = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         bus_req_i,
  input  logic                         bus_gnt_i,
  input  logic                         bus_rvalid_i,
  input  safety_periph_pkg::addr_t     bus_addr_i,
  input  logic [NumBusErrBits-1:0]     bus_err_i,
  input  logic                         reg_req_i,
  input  logic                         reg_we_i,
  input  safety_periph_pkg::reg_off_t  reg_addr_i,
  input  safety_periph_pkg::data_t     reg_wdata_i,
  output safety_periph_pkg::data_t     reg_rdata_o,
  output logic                         reg_error_o,
  output logic                         err_irq_o
);
  import safety_periph_pkg::*;

  localparam int unsigned OutPtrW = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;
  localparam int unsigned LogIdxW = (NumStoredErrors > 1) ? $clog2(NumStoredErrors) : 1;
  localparam int unsigned LogCntW = $clog2(NumStoredErrors + 1);
  localparam int unsigned EntryW  = $bits(addr_t) + NumBusErrBits;

  // Addresses of granted requests, oldest at the read pointer
  addr_t              out_addr_q [NumOutstanding];
  logic [OutPtrW-1:0] out_wr_ptr_q, out_rd_ptr_q;
  logic               out_push;

  // Log entries, head at index 0
  logic [NumStoredErrors-1:0][EntryW-1:0] log_q, log_d;
  logic [LogCntW-1:0]                     log_cnt_q;
  logic [LogIdxW-1:0]                     log_wr_idx;
  logic log_ovf_q, log_full, log_err, log_push, log_pop, reg_pop;

  function automatic logic [OutPtrW-1:0] next_ptr(logic [OutPtrW-1:0] ptr);
    return (ptr == OutPtrW'(NumOutstanding - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign out_push = bus_req_i && bus_gnt_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_wr_ptr_q <= '0;
      out_rd_ptr_q <= '0;
    end else begin
      if (out_push) out_wr_ptr_q <= next_ptr(out_wr_ptr_q);
      if (bus_rvalid_i) out_rd_ptr_q <= next_ptr(out_rd_ptr_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_push) begin
      out_addr_q[out_wr_ptr_q] <= bus_addr_i;
    end
  end

  assign log_full   = (log_cnt_q == LogCntW'(NumStoredErrors));
  assign log_err    = bus_rvalid_i && (bus_err_i != '0);
  assign log_push   = log_err && !log_full; // Dropped when full
  assign log_pop    = reg_pop && (log_cnt_q != '0);
  assign log_wr_idx = LogIdxW'(log_cnt_q - LogCntW'(log_pop));

  always_comb begin
    log_d = log_pop ? (log_q >> EntryW) : log_q;
    if (log_push) begin
      log_d[log_wr_idx] = {out_addr_q[out_rd_ptr_q], bus_err_i};
    end
  end

  always_ff @(posedge clk_i) begin
    log_q <= log_d;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      log_cnt_q <= '0;
      log_ovf_q <= 1'b0;
    end else begin
      log_cnt_q <= log_cnt_q + LogCntW'(log_push) - LogCntW'(log_pop);
      if (log_err && log_full) begin
        log_ovf_q <= 1'b1;
      end else if (reg_pop && reg_wdata_i[31]) begin
        log_ovf_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    reg_pop     = 1'b0;
    if (reg_req_i) begin
      unique case (reg_addr_i)
        ErrRegStatus: begin
          reg_error_o = reg_we_i;
          reg_rdata_o = {log_ovf_q, 23'd0, 8'(log_cnt_q)};
        end
        ErrRegAddr: begin
          reg_error_o = reg_we_i;
          reg_rdata_o = log_q[0][EntryW-1 -: $bits(addr_t)];
        end
        ErrRegCode: begin
          reg_error_o = reg_we_i;
          reg_rdata_o = data_t'(log_q[0][NumBusErrBits-1:0]);
        end
        ErrRegPop: begin
          reg_error_o = !reg_we_i; // Write only
          reg_pop     = reg_we_i;
        end
        default: reg_error_o = 1'b1;
      endcase
    end
  end

  assign err_irq_o = (log_cnt_q != '0);

endmodule

`default_nettype wire

//--- design/cl_regbus_decoder.sv
/* AXI4-Lite slave for the core-local register bus. Handles one access at a
   time and routes it to one of four peers by address window */
`timescale 1ns/1ps
`default_nettype none

module cl_regbus_decoder #(
  parameter safety_periph_pkg::addr_t PeriphBaseAddr = 32'h0020_0000
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            s_awvalid_i,
  output logic                            s_awready_o,
  input  safety_periph_pkg::addr_t        s_awaddr_i,
  input  logic                            s_wvalid_i,
  output logic                            s_wready_o,
  input  safety_periph_pkg::data_t        s_wdata_i,
  input  logic [3:0]                      s_wstrb_i,
  output logic                            s_bvalid_o,
  input  logic                            s_bready_i,
  output safety_periph_pkg::axi_resp_t    s_bresp_o,
  input  logic                            s_arvalid_i,
  output logic                            s_arready_o,
  input  safety_periph_pkg::addr_t        s_araddr_i,
  output logic                            s_rvalid_o,
  input  logic                            s_rready_i,
  output safety_periph_pkg::data_t        s_rdata_o,
  output safety_periph_pkg::axi_resp_t    s_rresp_o,
  output logic [3:0]                      reg_req_o,
  output logic                            reg_we_o,
  output safety_periph_pkg::reg_off_t     reg_addr_o,
  output safety_periph_pkg::data_t        reg_wdata_o,
  output logic [3:0]                      reg_wstrb_o,
  input  safety_periph_pkg::data_t [3:0]  reg_rdata_i,
  input  logic [3:0]                      reg_error_i
);
  import safety_periph_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StWrResp,
    StRdResp
  } state_e;

  state_e      state_q;
  axi_resp_t   resp_q, acc_resp;
  data_t       rdata_q;
  addr_t       acc_addr, acc_off;
  logic        wr_acc, rd_acc, hit;
  periph_idx_t sel;

  function automatic logic in_window(addr_t off, addr_t win);
    addr_t rel;
    rel = off - win; // Wraps for offsets below the window
    return rel < PeriphWindowSize;
  endfunction

  // Writes win over a read offered in the same cycle
  assign wr_acc   = (state_q == StIdle) && s_awvalid_i && s_wvalid_i;
  assign rd_acc   = (state_q == StIdle) && s_arvalid_i && !wr_acc;
  assign acc_addr = wr_acc ? s_awaddr_i : s_araddr_i;
  assign acc_off  = acc_addr - PeriphBaseAddr;

  always_comb begin
    hit = 1'b1;
    sel = PeriphIrq;
    if (in_window(acc_off, IrqCtrlOffset)) begin
      sel = PeriphIrq;
    end else if (in_window(acc_off, InstrErrOffset)) begin
      sel = PeriphInstrErr;
    end else if (in_window(acc_off, DataErrOffset)) begin
      sel = PeriphDataErr;
    end else if (in_window(acc_off, ShadowErrOffset)) begin
      sel = PeriphShadowErr;
    end else begin
      hit = 1'b0;
    end
  end

  always_comb begin
    reg_req_o = '0;
    if ((wr_acc || rd_acc) && hit) begin
      reg_req_o[sel] = 1'b1;
    end
  end

  assign reg_we_o    = wr_acc;
  assign reg_addr_o  = acc_off[11:0];
  assign reg_wdata_o = s_wdata_i;
  assign reg_wstrb_o = s_wstrb_i;
  assign acc_resp    = (!hit || reg_error_i[sel]) ? RespSlvErr : RespOkay;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      resp_q  <= RespOkay;
    end else begin
      unique case (state_q)
        StIdle: begin
          if (wr_acc) begin
            state_q <= StWrResp;
            resp_q  <= acc_resp;
          end else if (rd_acc) begin
            state_q <= StRdResp;
            resp_q  <= acc_resp;
          end
        end
        StWrResp: if (s_bready_i) state_q <= StIdle;
        StRdResp: if (s_rready_i) state_q <= StIdle;
        default:  state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rdata_q <= hit ? reg_rdata_i[sel] : DecodeErrVal;
    end
  end

  assign s_awready_o = wr_acc;
  assign s_wready_o  = wr_acc;
  assign s_arready_o = rd_acc;
  assign s_bvalid_o  = (state_q == StWrResp);
  assign s_rvalid_o  = (state_q == StRdResp);
  assign s_bresp_o   = resp_q;
  assign s_rresp_o   = resp_q;
  assign s_rdata_o   = rdata_q;

endmodule

`default_nettype wire

//--- design/safety_periph_pkg.sv
/* Address map, register offsets, widths and response codes shared by the
   core-local peripherals. Imported by every design module of the project */
`default_nettype none

package safety_periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [11:0] reg_off_t;
  typedef logic [7:0]  irq_level_t;

  // Peer order on the register bus
  typedef enum logic [1:0] {
    PeriphIrq       = 2'd0,
    PeriphInstrErr  = 2'd1,
    PeriphDataErr   = 2'd2,
    PeriphShadowErr = 2'd3
  } periph_idx_t;

  // Window offsets above the peripheral base
  localparam addr_t IrqCtrlOffset   = 32'h0000_0000;
  localparam addr_t InstrErrOffset  = 32'h0000_1000;
  localparam addr_t DataErrOffset   = 32'h0000_2000;
  localparam addr_t ShadowErrOffset = 32'h0000_3000;

  localparam addr_t PeriphWindowSize = 32'h0000_1000;

  // Error unit registers
  localparam reg_off_t ErrRegStatus = 12'h000;
  localparam reg_off_t ErrRegAddr   = 12'h004;
  localparam reg_off_t ErrRegCode   = 12'h008;
  localparam reg_off_t ErrRegPop    = 12'h00C;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axi_resp_t;

  localparam data_t DecodeErrVal = 32'hBADC_AB1E; // Read data of unmapped space

  // First source id of each interrupt group
  localparam int unsigned IrqTimerBase  = 16;
  localparam int unsigned IrqBusErrBase = 18;
  localparam int unsigned IrqExtBase    = 32;

endpackage

`default_nettype wire
